// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0] addr_t;

    // wraps around, decode only cares about ordering
    typedef logic [7:0] inst_id_t;

    // jump layout of an instruction word
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_view_t;

    // register/immediate and branch layout, upper bits not decoded here
    typedef struct packed {
        logic [16:0] upper;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } ib_view_t;

    typedef union packed {
        j_view_t  j;
        ib_view_t ib;
    } inst_word_u;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        inst_word_u inst;
    } mem_resp_t;

    // one queue entry, also what decode sees
    typedef struct packed {
        addr_t      addr;
        inst_word_u inst;
        inst_id_t   inst_id;
    } fetch_resp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  is_br;
        logic  is_jmp;
        logic  taken;
        addr_t target;
    } pred_update_t;

    localparam int QUEUE_DEPTH    = 16;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

    localparam int BP_INDEX_BITS = 10;
    localparam int BP_ENTRIES    = 1 << BP_INDEX_BITS;
    // weakly not taken
    localparam logic [1:0] BP_CTR_INIT = 2'b01;

    localparam logic [6:0] JAL_OP  = 7'b1101111;
    localparam logic [6:0] JALR_OP = 7'b1100111;
    localparam logic [6:0] BR_OP   = 7'b1100011;
    localparam logic [2:0] JALR_F3 = 3'b000;

    localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

// ==== source/sync_queue.sv ====
`timescale 1ns/1ps

module sync_queue import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        wr_valid,
    input  fetch_resp_t wr_data,
    input  logic        rd_ready,
    output logic        wr_ready_next,
    output logic        rd_valid,
    output fetch_resp_t rd_data
);

    localparam logic [QUEUE_PTR_BITS:0] FULL_COUNT = (QUEUE_PTR_BITS + 1)'(QUEUE_DEPTH);

    fetch_resp_t                entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_BITS-1:0]  wr_ptr;
    logic [QUEUE_PTR_BITS-1:0]  rd_ptr;
    logic [QUEUE_PTR_BITS:0]    count;
    logic [QUEUE_PTR_BITS:0]    count_next;
    logic                       full;
    logic                       do_wr;
    logic                       do_rd;

    assign full     = (count == FULL_COUNT);
    assign rd_valid = (count != '0);
    assign rd_data  = entries[rd_ptr];

    // a write into a full queue is ignored, the writer never does that
    assign do_wr = wr_valid && !full && !flush;
    assign do_rd = rd_valid && rd_ready && !flush;

    // occupancy after this edge
    always_comb begin
        count_next = count;
        if (flush) begin
            count_next = '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10:   count_next = count + 1'b1;
                2'b01:   count_next = count - 1'b1;
                default: count_next = count;
            endcase
        end
    end

    // early ready, room for one more reply arriving next cycle
    assign wr_ready_next = (count_next < FULL_COUNT);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            count <= count_next;
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (do_wr) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (do_rd) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            entries[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== source/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  addr_t        pred_pc,
    input  pred_update_t pred_update,
    output addr_t        pred_next_pc
);

    logic [1:0] counters  [BP_ENTRIES];
    logic       entry_ok  [BP_ENTRIES];
    addr_t      targets   [BP_ENTRIES];

    logic [BP_INDEX_BITS-1:0] rd_idx;
    logic [BP_INDEX_BITS-1:0] wr_idx;
    logic                     pred_taken;
    logic                     train;
    logic [1:0]               ctr_old;
    logic [1:0]               ctr_new;

    // word aligned, skip the byte offset bits
    assign rd_idx = pred_pc[BP_INDEX_BITS+1:2];
    assign wr_idx = pred_update.pc[BP_INDEX_BITS+1:2];

    // upper counter bit set means 2 or 3, predict taken
    assign pred_taken   = entry_ok[rd_idx] && counters[rd_idx][1];
    assign pred_next_pc = pred_taken ? targets[rd_idx] : pred_pc + 32'd4;

    // only control transfers train the table
    assign train = pred_update.valid && (pred_update.is_br || pred_update.is_jmp);

    assign ctr_old = counters[wr_idx];

    // saturating step
    always_comb begin
        ctr_new = ctr_old;
        if (pred_update.taken) begin
            if (ctr_old != 2'b11) begin
                ctr_new = ctr_old + 2'd1;
            end
        end else begin
            if (ctr_old != 2'b00) begin
                ctr_new = ctr_old - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                counters[i] <= BP_CTR_INIT;
                entry_ok[i] <= 1'b0;
            end
        end else if (train) begin
            counters[wr_idx] <= ctr_new;
            entry_ok[wr_idx] <= 1'b1;
        end
    end

    // target store, only read once the entry is marked valid
    always_ff @(posedge clk) begin
        if (train) begin
            targets[wr_idx] <= pred_update.target;
        end
    end

endmodule

// ==== source/jal_predecode.sv ====
`timescale 1ns/1ps

module jal_predecode import fetch_pkg::*; (
    input  addr_t      last_pc,
    input  inst_word_u last_inst,
    output logic       is_jal,
    output logic       is_ctrl,
    output addr_t      jal_target
);

    logic  is_jalr;
    logic  is_branch;
    addr_t j_offset;

    // jump view gives the opcode class and the scattered offset bits
    assign is_jal = (last_inst.j.opcode == JAL_OP);

    // jalr needs funct3 as well, branches only the opcode
    assign is_jalr   = (last_inst.ib.opcode == JALR_OP) && (last_inst.ib.funct3 == JALR_F3);
    assign is_branch = (last_inst.ib.opcode == BR_OP);
    assign is_ctrl   = is_jalr || is_branch;

    // sign extended, bit 0 always zero
    assign j_offset = {
        {11{last_inst.j.imm20}},
        last_inst.j.imm20,
        last_inst.j.imm19_12,
        last_inst.j.imm11,
        last_inst.j.imm10_1,
        1'b0
    };

    assign jal_target = last_pc + j_offset;

endmodule

// ==== source/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req_ready,
    input  mem_resp_t   mem_resp,
    input  redirect_t   redirect,
    input  logic        queue_wr_ready_next,
    input  addr_t       pred_next_pc,
    input  logic        is_jal,
    input  logic        is_ctrl,
    input  addr_t       jal_target,
    output mem_req_t    mem_req,
    output logic        queue_wr_valid,
    output fetch_resp_t queue_wr_data,
    output logic        queue_flush,
    output addr_t       pred_pc,
    output addr_t       last_pc,
    output inst_word_u  last_inst
);

    addr_t    pc;
    addr_t    request_addr;
    addr_t    next_pc;
    inst_id_t inst_id;
    logic     requested;
    logic     fetch_en;
    logic     resp_hit;
    logic     jal_hazard;
    logic     issue;

    // reply for the one outstanding request
    assign resp_hit = requested && mem_resp.valid && (mem_resp.addr == request_addr);

    // word in flight is not the jump target, so it is on the wrong path
    assign jal_hazard = is_jal && requested && (request_addr != jal_target);

    // predictor looks up where fetch goes next
    assign pred_pc = redirect.valid ? redirect.addr :
                     jal_hazard     ? jal_target    :
                     pc;

    // a plain jal overrides the predictor
    assign next_pc = (is_jal && !is_ctrl) ? jal_target + 32'd4 : pred_next_pc;

    // one request at a time, and only when the reply is sure to fit
    assign mem_req.valid = fetch_en && queue_wr_ready_next && !redirect.valid && !jal_hazard
                           && (!requested || resp_hit);
    assign mem_req.addr  = pc;
    assign issue         = mem_req.valid && mem_req_ready;

    assign queue_flush    = redirect.valid;
    assign queue_wr_valid = resp_hit && !jal_hazard && !redirect.valid;

    // ids follow queue writes so decode sees them without gaps
    assign queue_wr_data.addr    = request_addr;
    assign queue_wr_data.inst    = mem_resp.inst;
    assign queue_wr_data.inst_id = inst_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= RESET_PC;
            request_addr <= RESET_PC;
            requested    <= 1'b0;
            fetch_en     <= 1'b0;
            inst_id      <= '0;
            last_pc      <= '0;
            last_inst    <= '0;
        end else begin
            // first request goes out one cycle after reset
            fetch_en <= 1'b1;

            if (redirect.valid) begin
                // misprediction from execute, old reply gets ignored
                pc        <= redirect.addr;
                requested <= 1'b0;
                last_pc   <= '0;
                last_inst <= '0;
            end else if (jal_hazard) begin
                // drop the wrong path word and restart at the target
                pc        <= jal_target;
                requested <= 1'b0;
                last_pc   <= '0;
                last_inst <= '0;
            end else begin
                if (resp_hit) begin
                    last_pc   <= request_addr;
                    last_inst <= mem_resp.inst;
                end

                if (issue) begin
                    requested    <= 1'b1;
                    request_addr <= pc;
                    pc           <= next_pc;
                end else if (resp_hit) begin
                    requested <= 1'b0;
                end
            end

            if (queue_wr_valid) begin
                inst_id <= inst_id + 1'b1;
            end
        end
    end

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         mem_req_ready,
    input  mem_resp_t    mem_resp,
    input  logic         fetch_ready,
    input  redirect_t    redirect,
    input  pred_update_t pred_update,
    output mem_req_t     mem_req,
    output fetch_resp_t  fetch_resp,
    output logic         fetch_valid
);

    // fetch to queue
    logic        queue_wr_valid;
    fetch_resp_t queue_wr_data;
    logic        queue_flush;
    logic        queue_wr_ready_next;

    // fetch to predictor
    addr_t       pred_pc;
    addr_t       pred_next_pc;

    // fetch to predecode
    addr_t       last_pc;
    inst_word_u  last_inst;
    logic        is_jal;
    logic        is_ctrl;
    addr_t       jal_target;

    inst_fetch u_inst_fetch (
        .clk                 (clk),
        .rst                 (rst),
        .mem_req_ready       (mem_req_ready),
        .mem_resp            (mem_resp),
        .redirect            (redirect),
        .queue_wr_ready_next (queue_wr_ready_next),
        .pred_next_pc        (pred_next_pc),
        .is_jal              (is_jal),
        .is_ctrl             (is_ctrl),
        .jal_target          (jal_target),
        .mem_req             (mem_req),
        .queue_wr_valid      (queue_wr_valid),
        .queue_wr_data       (queue_wr_data),
        .queue_flush         (queue_flush),
        .pred_pc             (pred_pc),
        .last_pc             (last_pc),
        .last_inst           (last_inst)
    );

    jal_predecode u_jal_predecode (
        .last_pc    (last_pc),
        .last_inst  (last_inst),
        .is_jal     (is_jal),
        .is_ctrl    (is_ctrl),
        .jal_target (jal_target)
    );

    branch_predictor u_branch_predictor (
        .clk          (clk),
        .rst          (rst),
        .pred_pc      (pred_pc),
        .pred_update  (pred_update),
        .pred_next_pc (pred_next_pc)
    );

    sync_queue u_sync_queue (
        .clk           (clk),
        .rst           (rst),
        .flush         (queue_flush),
        .wr_valid      (queue_wr_valid),
        .wr_data       (queue_wr_data),
        .rd_ready      (fetch_ready),
        .wr_ready_next (queue_wr_ready_next),
        .rd_valid      (fetch_valid),
        .rd_data       (fetch_resp)
    );

endmodule

// ==== sim/inst_mem_model.sv ====
`timescale 1ns/1ps

module inst_mem_model import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  mem_req_t  mem_req,
    output logic      mem_req_ready,
    output mem_resp_t mem_resp
);

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    // beq x0, x0, +0x80
    localparam logic [31:0] BEQ_WORD = 32'h0800_0063;
    // words below this address are distinct addi instructions
    localparam addr_t LOW_AREA_END = 32'h0000_0100;

    logic       pending;
    logic [1:0] wait_cnt;
    addr_t      pend_addr;

    // jal x1 with a byte offset
    function automatic logic [31:0] jal_word(int offset);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, JAL_OP};
    endfunction

    // addi x1, x1, low address bits
    function automatic logic [31:0] addi_word(addr_t addr);
        return {addr[11:0], 5'd1, 3'b000, 5'd1, 7'b0010011};
    endfunction

    // program table
    function automatic inst_word_u lookup(addr_t addr);
        inst_word_u w;
        case (addr)
            32'h0000_0108: w = jal_word(64);
            32'h0000_0204: w = jal_word(-448);
            32'h0000_0400: w = BEQ_WORD;
            default: begin
                if (addr < LOW_AREA_END) begin
                    w = addi_word(addr);
                end else begin
                    w = NOP_WORD;
                end
            end
        endcase
        return w;
    endfunction

    initial begin
        void'($urandom(8774));
    end

    assign mem_req_ready  = !pending;
    assign mem_resp.valid = pending && (wait_cnt == 2'd0);
    assign mem_resp.addr  = pend_addr;
    assign mem_resp.inst  = lookup(pend_addr);

    // latency of 1 to 3 cycles per request
    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            wait_cnt  <= 2'd0;
            pend_addr <= '0;
        end else if (pending) begin
            if (wait_cnt == 2'd0) begin
                pending <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else if (mem_req.valid) begin
            pending   <= 1'b1;
            pend_addr <= mem_req.addr;
            wait_cnt  <= 2'($urandom_range(2, 0));
        end
    end

endmodule

// ==== sim/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb import fetch_pkg::*; ();

    typedef enum logic [1:0] {
        ROW_RUN,
        ROW_REDIRECT,
        ROW_UPDATE,
        ROW_STALL
    } row_kind_e;

    // expected addresses are two sequential runs, a then b
    typedef struct packed {
        row_kind_e   kind;
        addr_t       addr;
        addr_t       target;
        logic        taken;
        logic [15:0] cycles;
        addr_t       exp_a;
        logic [4:0]  n_a;
        addr_t       exp_b;
        logic [4:0]  n_b;
    } stim_row_t;

    localparam int NUM_ROWS      = 8;
    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 5;
    // tail of a stall where the queue must already be full
    localparam int FULL_WINDOW   = 8;

    logic         clk;
    logic         rst;
    logic         mem_req_ready;
    logic         fetch_ready;
    logic         fetch_valid;
    mem_req_t     mem_req;
    mem_resp_t    mem_resp;
    redirect_t    redirect;
    pred_update_t pred_update;
    fetch_resp_t  fetch_resp;

    fetch_resp_t  delivered [$];
    inst_id_t     next_id;
    logic         id_resync;
    int           value_errors;
    int           other_errors;

    fetch_unit UUT (
        .clk           (clk),
        .rst           (rst),
        .mem_req_ready (mem_req_ready),
        .mem_resp      (mem_resp),
        .fetch_ready   (fetch_ready),
        .redirect      (redirect),
        .pred_update   (pred_update),
        .mem_req       (mem_req),
        .fetch_resp    (fetch_resp),
        .fetch_valid   (fetch_valid)
    );

    inst_mem_model u_mem (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_resp      (mem_resp)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    function automatic stim_row_t make_row(row_kind_e kind, addr_t addr, addr_t target,
                                           logic taken, int cycles, addr_t exp_a, int n_a,
                                           addr_t exp_b, int n_b);
        stim_row_t r;
        r.kind   = kind;
        r.addr   = addr;
        r.target = target;
        r.taken  = taken;
        r.cycles = 16'(cycles);
        r.exp_a  = exp_a;
        r.n_a    = 5'(n_a);
        r.exp_b  = exp_b;
        r.n_b    = 5'(n_b);
        return r;
    endfunction

    function automatic stim_row_t get_row(int idx);
        case (idx)
            // sequential from reset
            0: return make_row(ROW_RUN, 32'h0, 32'h0, 1'b0, 60, 32'h0, 8, 32'h0, 0);
            // jal forward at 0x108, offset +0x40
            1: return make_row(ROW_REDIRECT, 32'h100, 32'h0, 1'b0, 40, 32'h100, 3, 32'h148, 3);
            // jal backward at 0x204, offset -0x1c0
            2: return make_row(ROW_REDIRECT, 32'h200, 32'h0, 1'b0, 40, 32'h200, 2, 32'h044, 3);
            3: return make_row(ROW_STALL, 32'h300, 32'h0, 1'b0, 100, 32'h300, 16, 32'h0, 0);
            4: return make_row(ROW_UPDATE, 32'h400, 32'h480, 1'b1, 2, 32'h0, 0, 32'h0, 0);
            5: return make_row(ROW_REDIRECT, 32'h400, 32'h0, 1'b0, 40, 32'h400, 1, 32'h480, 2);
            6: return make_row(ROW_UPDATE, 32'h400, 32'h480, 1'b0, 2, 32'h0, 0, 32'h0, 0);
            default: return make_row(ROW_REDIRECT, 32'h400, 32'h0, 1'b0, 40, 32'h400, 3, 32'h0, 0);
        endcase
    endfunction

    function automatic int total_cycles();
        stim_row_t r;
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = get_row(i);
            sum += int'(r.cycles);
        end
        return sum;
    endfunction

    task automatic check_resp(fetch_resp_t got, fetch_resp_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %0t: got addr %h inst %h id %0d, expected addr %h inst %h id %0d",
                     $time, got.addr, got.inst, got.inst_id, exp.addr, exp.inst, exp.inst_id);
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %0t: request address %h, expected %h", $time, got, exp);
        end
    endtask

    // scoreboard, sampled mid cycle where everything is settled
    always @(negedge clk) begin
        if (!rst && fetch_valid && fetch_ready && !redirect.valid) begin
            delivered.push_back(fetch_resp);
        end
    end

    task automatic step_cycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_deliveries(int needed, int limit);
        int n;
        n = 0;
        while (delivered.size() < needed && n < limit) begin
            step_cycles(1);
            n++;
        end
    endtask

    task automatic pulse_redirect(addr_t addr);
        redirect.valid = 1'b1;
        redirect.addr  = addr;
        // queue flush skips ids
        id_resync      = 1'b1;
        step_cycles(1);
        redirect = '0;
        // first request after the flush starts at the new address
        @(negedge clk);
        if (mem_req.valid !== 1'b1) begin
            value_errors++;
            $display("ERROR %0t: no fetch request in the cycle after the redirect", $time);
        end
        check_addr(mem_req.addr, addr);
    endtask

    task automatic pulse_update(addr_t pc, addr_t target, logic taken);
        pred_update.valid  = 1'b1;
        pred_update.pc     = pc;
        pred_update.is_br  = 1'b1;
        pred_update.is_jmp = 1'b0;
        pred_update.taken  = taken;
        pred_update.target = target;
        step_cycles(1);
        pred_update = '0;
    endtask

    task automatic hold_stall(int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (i >= n - FULL_WINDOW) begin
                if (mem_req.valid !== 1'b0 || fetch_valid !== 1'b1) begin
                    value_errors++;
                    $display("ERROR %0t: queue full expected, mem_req.valid %b fetch_valid %b",
                             $time, mem_req.valid, fetch_valid);
                end
            end
            step_cycles(1);
        end
    endtask

    task automatic check_row(int idx, stim_row_t row);
        int          needed;
        inst_id_t    base_id;
        fetch_resp_t exp;
        needed  = int'(row.n_a) + int'(row.n_b);
        base_id = next_id;
        if (id_resync && delivered.size() > 0) begin
            // flushed entries already took their ids
            base_id = delivered[0].inst_id;
        end
        if (delivered.size() < needed) begin
            other_errors++;
            $display("row %0d: only %0d of %0d words were delivered before the time ran out",
                     idx, delivered.size(), needed);
        end else begin
            for (int k = 0; k < needed; k++) begin
                if (k < int'(row.n_a)) begin
                    exp.addr = row.exp_a + addr_t'(4 * k);
                end else begin
                    exp.addr = row.exp_b + addr_t'(4 * (k - int'(row.n_a)));
                end
                exp.inst    = u_mem.lookup(exp.addr);
                exp.inst_id = base_id + inst_id_t'(k);
                check_resp(delivered[k], exp);
            end
        end
        id_resync = 1'b0;
        next_id   = base_id + inst_id_t'(delivered.size());
    endtask

    task automatic apply_row(int idx);
        stim_row_t row;
        int        needed;
        row    = get_row(idx);
        needed = int'(row.n_a) + int'(row.n_b);
        delivered.delete();
        case (row.kind)
            ROW_RUN: wait_deliveries(needed, int'(row.cycles));
            ROW_REDIRECT: begin
                pulse_redirect(row.addr);
                wait_deliveries(needed, int'(row.cycles) - 1);
            end
            ROW_UPDATE: begin
                pulse_update(row.addr, row.target, row.taken);
                step_cycles(int'(row.cycles) - 1);
            end
            default: begin
                fetch_ready = 1'b0;
                pulse_redirect(row.addr);
                hold_stall(int'(row.cycles) - 1);
                fetch_ready = 1'b1;
                wait_deliveries(needed, int'(row.cycles));
            end
        endcase
        check_row(idx, row);
    endtask

    initial begin
        rst          = 1'b1;
        fetch_ready  = 1'b1;
        redirect     = '0;
        pred_update  = '0;
        next_id      = '0;
        id_resync    = 1'b0;
        value_errors = 0;
        other_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog, four times the table length
    initial begin
        int limit_ns;
        limit_ns = total_cycles() * 4 * CLK_PERIOD_NS;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
source/fetch_pkg.sv
source/sync_queue.sv
source/branch_predictor.sv
source/jal_predecode.sv
source/inst_fetch.sv
source/fetch_unit.sv
sim/inst_mem_model.sv
sim/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module fetch_unit_tb -Mdir obj_dir \
    -o fetch_unit_sim -f build.f > compile.log 2>&1 \
    || { echo "compile failed, see compile.log"; exit 1; }

./obj_dir/fetch_unit_sim 2>&1 | tee sim.log \
    || { echo "simulator exited with an error"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "SIMULATION PASSED" sim.log && exit 0 \
    || { echo "result: no verdict in sim.log"; exit 1; }
